/* Bender.yml */
package:
  name: ooo_core

sources:
  - verilog/ooo_pkg.sv
  - verilog/issue_stage.sv
  - verilog/reorder_buffer.sv
  - verilog/commit_unit.sv
  - verilog/ooo_core_top.sv
  - target: test
    files:
      - test/tb_ooo_core.sv

/* src.f */
verilog/ooo_pkg.sv
verilog/issue_stage.sv
verilog/reorder_buffer.sv
verilog/commit_unit.sv
verilog/ooo_core_top.sv
test/tb_ooo_core.sv

/* test/tb_ooo_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core import ooo_pkg::*; ();

  localparam int ROB_DEPTH = 8;
  localparam int TAG_W = $clog2(ROB_DEPTH);
  localparam int MAX_N = 64;
  localparam int N_RAND = 48;
  localparam int N_FULL = ROB_DEPTH + 3;
  localparam int WATCHDOG_CYCLES = 200 * (N_RAND + N_FULL);

  logic             clk_in;
  logic             rst_in;
  logic             insn_valid;
  insn_class_t      insn_class;
  reg_ix_t          insn_dest;
  reg_ix_t          insn_src1;
  reg_ix_t          insn_src2;
  logic             insn_ready;
  logic [TAG_W-1:0] issue_tag;
  logic             src1_ready;
  data_t            src1_value;
  logic [TAG_W-1:0] src1_tag;
  logic             src2_ready;
  data_t            src2_value;
  logic [TAG_W-1:0] src2_tag;
  logic             cdb_valid;
  logic [TAG_W-1:0] cdb_tag;
  data_t            cdb_value;
  data_t            cdb_addr;
  logic             commit_valid;
  reg_ix_t          commit_dest;
  data_t            commit_value;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  data_t            wb_adr;
  data_t            wb_dat_w;
  logic [3:0]       wb_sel;
  logic             wb_ack = 1'b0;

  // program under test
  insn_class_t      p_cls  [MAX_N];
  reg_ix_t          p_dest [MAX_N];
  reg_ix_t          p_src1 [MAX_N];
  reg_ix_t          p_src2 [MAX_N];
  logic [TAG_W-1:0] p_tag  [MAX_N];
  data_t            p_val  [MAX_N];
  data_t            p_adr  [MAX_N];
  int               prog_n;

  // reference operand producers and visible retirements in order
  int      prod1 [MAX_N];
  int      prod2 [MAX_N];
  data_t   expv1 [MAX_N];
  data_t   expv2 [MAX_N];
  bit      ev_store [MAX_N];
  reg_ix_t ev_dest  [MAX_N];
  data_t   ev_val   [MAX_N];
  data_t   ev_adr   [MAX_N];
  int      ev_cnt;
  int      st_cnt;
  int      ev_idx = 0;

  // execution model state
  int issue_idx;
  int pend [MAX_N];
  int pend_cnt;
  int cdb_prev;
  bit done_tb [MAX_N];

  int ack_wait = 0;
  int wr_count = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err0;
  int n_fwd;
  int n_wait;
  int n_rf;
  int n_zero;

  ooo_core_top #(.ROB_DEPTH(ROB_DEPTH)) u_ooo_core_top (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .insn_valid   (insn_valid),
    .insn_class   (insn_class),
    .insn_dest    (insn_dest),
    .insn_src1    (insn_src1),
    .insn_src2    (insn_src2),
    .insn_ready   (insn_ready),
    .issue_tag    (issue_tag),
    .src1_ready   (src1_ready),
    .src1_value   (src1_value),
    .src1_tag     (src1_tag),
    .src2_ready   (src2_ready),
    .src2_value   (src2_value),
    .src2_tag     (src2_tag),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_value    (cdb_value),
    .cdb_addr     (cdb_addr),
    .commit_valid (commit_valid),
    .commit_dest  (commit_dest),
    .commit_value (commit_value),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_sel       (wb_sel),
    .wb_ack       (wb_ack)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  function automatic void make_program(input int n, input bit all_alu);
    int r;
    for (int i = 0; i < n; i++) begin
      r = $urandom_range(0, 9);
      if (all_alu || r < 6) begin
        p_cls[i] = CLASS_ALU;
      end else if (r < 8) begin
        p_cls[i] = CLASS_STORE;
      end else begin
        p_cls[i] = CLASS_NOP;
      end
      p_dest[i] = reg_ix_t'($urandom_range(0, 7));
      p_src1[i] = reg_ix_t'($urandom_range(0, 7));
      p_src2[i] = reg_ix_t'($urandom_range(0, 7));
      // tail counts up from slot 0 after reset
      p_tag[i] = TAG_W'(i);
      p_val[i] = {8'(p_tag[i]), 8'h5a, 16'(i)};
      p_adr[i] = '0;
      if (p_cls[i] == CLASS_STORE) begin
        p_adr[i] = $urandom & 32'hffff_fffc;
        p_val[i] = $urandom;
      end
    end
    prog_n = n;
  endfunction

  // walks the program in order from a cleared register file
  function automatic void compute_reference(input int n);
    data_t ref_rf  [32];
    int    last_wr [32];
    for (int r = 0; r < 32; r++) begin
      ref_rf[r]  = '0;
      last_wr[r] = -1;
    end
    ev_cnt = 0;
    st_cnt = 0;
    for (int i = 0; i < n; i++) begin
      prod1[i] = last_wr[p_src1[i]];
      prod2[i] = last_wr[p_src2[i]];
      expv1[i] = ref_rf[p_src1[i]];
      expv2[i] = ref_rf[p_src2[i]];
      if (p_cls[i] != CLASS_NOP) begin
        ev_store[ev_cnt] = (p_cls[i] == CLASS_STORE);
        ev_dest[ev_cnt]  = p_dest[i];
        ev_val[ev_cnt]   = p_val[i];
        ev_adr[ev_cnt]   = p_adr[i];
        ev_cnt++;
      end
      if (p_cls[i] == CLASS_STORE) begin
        st_cnt++;
      end
      // x0 is never renamed or written
      if (p_cls[i] == CLASS_ALU && p_dest[i] != 0) begin
        ref_rf[p_dest[i]]  = p_val[i];
        last_wr[p_dest[i]] = i;
      end
    end
  endfunction

  task automatic check_operand(input int idx, input int which, input reg_ix_t src,
                               input int prod, input data_t expv, input logic rdy,
                               input data_t val, input logic [TAG_W-1:0] tag);
    if (prod >= 0 && !done_tb[prod]) begin
      n_wait++;
      assert (rdy == 1'b0 && tag == p_tag[prod]) else begin
        $display("[ERROR] insn %0d src%0d_ready exp 0 got %h, src%0d_tag exp %h got %h",
                 idx, which, rdy, which, p_tag[prod], tag);
        errors++;
      end
    end else begin
      if (src == 0) begin
        n_zero++;
      end else if (prod < 0) begin
        n_rf++;
      end else begin
        n_fwd++;
      end
      assert (rdy == 1'b1 && val == expv) else begin
        $display("[ERROR] insn %0d src%0d_value exp %h got %h (src%0d_ready %h)",
                 idx, which, expv, val, which, rdy);
        errors++;
      end
    end
  endtask

  // one clock of intake and execution right after a rising edge
  task automatic step(input bit hold);
    int k;
    int id;
    if (insn_valid && insn_ready) begin
      assert (issue_tag == p_tag[issue_idx]) else begin
        $display("[ERROR] insn %0d issue_tag exp %h got %h", issue_idx, p_tag[issue_idx],
                 issue_tag);
        errors++;
      end
      check_operand(issue_idx, 1, p_src1[issue_idx], prod1[issue_idx], expv1[issue_idx],
                    src1_ready, src1_value, src1_tag);
      check_operand(issue_idx, 2, p_src2[issue_idx], prod2[issue_idx], expv2[issue_idx],
                    src2_ready, src2_value, src2_tag);
      if (p_cls[issue_idx] != CLASS_NOP) begin
        pend[pend_cnt] = issue_idx;
        pend_cnt++;
      end
      issue_idx++;
    end
    // strobe sampled at this edge marks its entry done
    if (cdb_prev >= 0) begin
      done_tb[cdb_prev] = 1'b1;
    end
    cdb_prev = -1;
    if (!hold && pend_cnt > 0) begin
      k = $urandom_range(0, pend_cnt - 1);
      id = pend[k];
      pend[k] = pend[pend_cnt - 1];
      pend_cnt--;
      cdb_prev = id;
      cdb_valid <= 1'b1;
      cdb_tag   <= p_tag[id];
      cdb_value <= p_val[id];
      cdb_addr  <= p_adr[id];
    end else begin
      cdb_valid <= 1'b0;
    end
    if (issue_idx < prog_n) begin
      insn_valid <= 1'b1;
      insn_class <= p_cls[issue_idx];
      insn_dest  <= p_dest[issue_idx];
      insn_src1  <= p_src1[issue_idx];
      insn_src2  <= p_src2[issue_idx];
    end else begin
      insn_valid <= 1'b0;
    end
  endtask

  task automatic reset_and_load(input int n, input bit all_alu);
    @(posedge clk_in);
    rst_in     <= 1'b1;
    insn_valid <= 1'b0;
    cdb_valid  <= 1'b0;
    @(posedge clk_in);
    make_program(n, all_alu);
    compute_reference(n);
    issue_idx = 0;
    pend_cnt  = 0;
    cdb_prev  = -1;
    for (int i = 0; i < MAX_N; i++) begin
      done_tb[i] = 1'b0;
    end
    repeat (2) @(posedge clk_in);
    rst_in <= 1'b0;
  endtask

  task automatic run_program(input int max_cycles, input string name);
    int cyc;
    cyc = 0;
    while (!(issue_idx == prog_n && pend_cnt == 0 && ev_idx == ev_cnt) &&
           cyc < max_cycles) begin
      @(posedge clk_in);
      step(1'b0);
      cyc++;
    end
    assert (cyc < max_cycles) else begin
      $display("%s: program did not retire within %0d cycles", name, max_cycles);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_err0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_err0);
    end
  endtask

  // wishbone slave with a one-cycle ack after a random wait
  always @(posedge clk_in) begin
    if (rst_in) begin
      wb_ack   <= 1'b0;
      ack_wait <= $urandom_range(0, 3);
      wr_count <= 0;
    end else if (wb_ack) begin
      wb_ack   <= 1'b0;
      wr_count <= wr_count + 1;
    end else if (wb_cyc && wb_stb) begin
      if (ack_wait == 0) begin
        wb_ack   <= 1'b1;
        ack_wait <= $urandom_range(0, 3);
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  // compares every retirement against the reference sequence
  always @(posedge clk_in) begin
    if (rst_in) begin
      ev_idx <= 0;
    end else begin
      if (commit_valid) begin
        assert (ev_idx < ev_cnt && !ev_store[ev_idx]) else begin
          $display("commit of x%0d arrived where no ALU retirement was due", commit_dest);
          errors++;
        end
        if (ev_idx < ev_cnt && !ev_store[ev_idx]) begin
          assert (commit_dest == ev_dest[ev_idx] && commit_value == ev_val[ev_idx]) else begin
            $display("[ERROR] commit_dest exp %h got %h, commit_value exp %h got %h",
                     ev_dest[ev_idx], commit_dest, ev_val[ev_idx], commit_value);
            errors++;
          end
        end
        ev_idx <= ev_idx + 1;
      end
      if (wb_cyc && wb_stb && wb_ack) begin
        assert (ev_idx < ev_cnt && ev_store[ev_idx]) else begin
          $display("bus write to %h arrived where no store was due", wb_adr);
          errors++;
        end
        if (ev_idx < ev_cnt && ev_store[ev_idx]) begin
          assert (wb_adr == ev_adr[ev_idx] && wb_dat_w == ev_val[ev_idx]) else begin
            $display("[ERROR] wb_adr exp %h got %h, wb_dat_w exp %h got %h",
                     ev_adr[ev_idx], wb_adr, ev_val[ev_idx], wb_dat_w);
            errors++;
          end
        end
        assert (wb_we && wb_sel == 4'hf) else begin
          $display("[ERROR] wb_we exp 1 got %h, wb_sel exp f got %h", wb_we, wb_sel);
          errors++;
        end
        ev_idx <= ev_idx + 1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_in);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(59));
    rst_in     <= 1'b1;
    insn_valid <= 1'b0;
    insn_class <= CLASS_NOP;
    insn_dest  <= '0;
    insn_src1  <= '0;
    insn_src2  <= '0;
    cdb_valid  <= 1'b0;
    cdb_tag    <= '0;
    cdb_value  <= '0;
    cdb_addr   <= '0;

    test_err0 = errors;
    reset_and_load(0, 1'b0);
    @(posedge clk_in);
    assert (!commit_valid && !wb_cyc && !wb_stb && insn_ready) else begin
      $display("[ERROR] after reset commit_valid %h wb_cyc %h wb_stb %h insn_ready %h",
               commit_valid, wb_cyc, wb_stb, insn_ready);
      errors++;
    end
    finish_test("reset_state");

    // random mix with out of order completion
    test_err0 = errors;
    reset_and_load(N_RAND, 1'b0);
    n_fwd  = 0;
    n_wait = 0;
    n_rf   = 0;
    n_zero = 0;
    run_program(100 * N_RAND, "random_program");
    assert (wr_count == st_cnt) else begin
      $display("[ERROR] wr_count exp %h got %h", st_cnt, wr_count);
      errors++;
    end
    assert (n_fwd > 0 && n_wait > 0 && n_rf > 0 && n_zero > 0) else begin
      $display("operand cases not all reached: fwd %0d wait %0d rf %0d zero %0d",
               n_fwd, n_wait, n_rf, n_zero);
      errors++;
    end
    finish_test("random_program");

    // completions withheld until the buffer fills
    test_err0 = errors;
    reset_and_load(N_FULL, 1'b1);
    repeat (3 * ROB_DEPTH) begin
      @(posedge clk_in);
      step(1'b1);
    end
    assert (issue_idx == ROB_DEPTH && !insn_ready) else begin
      $display("[ERROR] accepted while full exp %h got %h, insn_ready %h",
               ROB_DEPTH, issue_idx, insn_ready);
      errors++;
    end
    run_program(100 * N_FULL, "backpressure");
    assert (issue_idx == N_FULL) else begin
      $display("[ERROR] accepted after release exp %h got %h", N_FULL, issue_idx);
      errors++;
    end
    finish_test("backpressure");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/commit_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module commit_unit import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire              clk_in,
  input  wire              rst_in,
  input  wire              head_valid,
  input  wire insn_class_t head_class,
  input  wire reg_ix_t     head_dest,
  input  wire data_t       head_value,
  input  wire data_t       head_addr,
  output logic             retire,
  input  wire reg_ix_t     rf_addr1,
  input  wire reg_ix_t     rf_addr2,
  output data_t            rf_data1,
  output data_t            rf_data2,
  output logic             commit_valid,
  output reg_ix_t          commit_dest,
  output data_t            commit_value,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output data_t            wb_adr,
  output data_t            wb_dat_w,
  output logic [3:0]       wb_sel,
  input  wire              wb_ack
);

  // head and tail wrap relies on a power of two depth
  if ((ROB_DEPTH & (ROB_DEPTH - 1)) != 0 || ROB_DEPTH < 2) begin : g_depth_check
    $error("ROB_DEPTH must be a power of two, got %0d", ROB_DEPTH);
  end

  // architectural register file
  data_t rf_q [32];

  logic store_req;

  assign store_req = head_valid && (head_class == CLASS_STORE);

  // alu and nop retire at once while a store waits for its ack
  assign retire = head_valid && (head_class != CLASS_STORE || wb_ack);

  assign commit_valid = head_valid && (head_class == CLASS_ALU);
  assign commit_dest  = head_dest;
  assign commit_value = head_value;

  // wishbone classic write held by the head until ack
  assign wb_cyc   = store_req;
  assign wb_stb   = store_req;
  assign wb_we    = store_req;
  assign wb_adr   = head_addr;
  assign wb_dat_w = head_value;
  assign wb_sel   = 4'hf;

  // x0 reads as zero
  assign rf_data1 = (rf_addr1 == '0) ? '0 : rf_q[rf_addr1];
  assign rf_data2 = (rf_addr2 == '0) ? '0 : rf_q[rf_addr2];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (commit_valid && head_dest != '0) begin
      rf_q[head_dest] <= head_value;
    end
  end

  // head must not move while a write is pending on the bus
  a_wb_hold: assert property (
    @(posedge clk_in) disable iff (rst_in)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w)
  ) else $error("wishbone request changed before ack");

endmodule

`default_nettype wire

/* verilog/issue_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_stage import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  wire              clk_in,
  input  wire              rst_in,
  input  wire              insn_valid,
  input  wire insn_class_t insn_class,
  input  wire reg_ix_t     insn_dest,
  input  wire reg_ix_t     insn_src1,
  input  wire reg_ix_t     insn_src2,
  output logic             insn_ready,
  output logic [TAG_W-1:0] issue_tag,
  output logic             src1_ready,
  output data_t            src1_value,
  output logic [TAG_W-1:0] src1_tag,
  output logic             src2_ready,
  output data_t            src2_value,
  output logic [TAG_W-1:0] src2_tag,
  output logic             alloc_valid,
  output insn_class_t      alloc_class,
  output reg_ix_t          alloc_dest,
  input  wire [TAG_W-1:0]  alloc_tag,
  input  wire              rob_full,
  output logic [TAG_W-1:0] look1_tag,
  output logic [TAG_W-1:0] look2_tag,
  input  wire data_t       look1_value,
  input  wire              look1_done,
  input  wire data_t       look2_value,
  input  wire              look2_done,
  output reg_ix_t          rf_addr1,
  output reg_ix_t          rf_addr2,
  input  wire data_t       rf_data1,
  input  wire data_t       rf_data2,
  input  wire              retire,
  input  wire [TAG_W-1:0]  head_tag
);

  // rename table with a busy bit and owning tag per register
  logic [31:0]      busy_q;
  logic [TAG_W-1:0] owner_q [32];

  // returns {ready, value} for one source operand
  function automatic logic [DATA_W:0] pick_operand(
    input reg_ix_t src,
    input logic    busy,
    input logic    done,
    input data_t   rob_value,
    input data_t   rf_value
  );
    if (src == '0) begin
      return {1'b1, data_t'(0)};
    end else if (busy && done) begin
      return {1'b1, rob_value};
    end else if (busy) begin
      // producer still in flight
      return {1'b0, data_t'(0)};
    end
    return {1'b1, rf_value};
  endfunction

  assign insn_ready  = !rob_full;
  assign alloc_valid = insn_valid && insn_ready;
  assign alloc_class = insn_class;
  assign alloc_dest  = insn_dest;
  assign issue_tag   = alloc_tag;

  assign look1_tag = owner_q[insn_src1];
  assign look2_tag = owner_q[insn_src2];
  assign rf_addr1  = insn_src1;
  assign rf_addr2  = insn_src2;
  assign src1_tag  = owner_q[insn_src1];
  assign src2_tag  = owner_q[insn_src2];

  assign {src1_ready, src1_value} =
    pick_operand(insn_src1, busy_q[insn_src1], look1_done, look1_value, rf_data1);
  assign {src2_ready, src2_value} =
    pick_operand(insn_src2, busy_q[insn_src2], look2_done, look2_value, rf_data2);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= '0;
      for (int i = 0; i < 32; i++) begin
        owner_q[i] <= '0;
      end
    end else begin
      // drop a mapping only if the retiring entry is still its owner
      if (retire) begin
        for (int i = 1; i < 32; i++) begin
          if (busy_q[i] && owner_q[i] == head_tag) begin
            busy_q[i] <= 1'b0;
          end
        end
      end
      // a new claim wins over a same-cycle release
      if (alloc_valid && insn_class == CLASS_ALU && insn_dest != '0) begin
        busy_q[insn_dest]  <= 1'b1;
        owner_q[insn_dest] <= alloc_tag;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/ooo_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ooo_core_top import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  wire              clk_in,
  input  wire              rst_in,
  input  wire              insn_valid,
  input  wire insn_class_t insn_class,
  input  wire reg_ix_t     insn_dest,
  input  wire reg_ix_t     insn_src1,
  input  wire reg_ix_t     insn_src2,
  output logic             insn_ready,
  output logic [TAG_W-1:0] issue_tag,
  output logic             src1_ready,
  output data_t            src1_value,
  output logic [TAG_W-1:0] src1_tag,
  output logic             src2_ready,
  output data_t            src2_value,
  output logic [TAG_W-1:0] src2_tag,
  input  wire              cdb_valid,
  input  wire [TAG_W-1:0]  cdb_tag,
  input  wire data_t       cdb_value,
  input  wire data_t       cdb_addr,
  output logic             commit_valid,
  output reg_ix_t          commit_dest,
  output data_t            commit_value,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output data_t            wb_adr,
  output data_t            wb_dat_w,
  output logic [3:0]       wb_sel,
  input  wire              wb_ack
);

  // issue to buffer
  logic             alloc_valid;
  insn_class_t      alloc_class;
  reg_ix_t          alloc_dest;
  logic [TAG_W-1:0] alloc_tag;
  logic             rob_full;
  logic [TAG_W-1:0] look1_tag;
  logic [TAG_W-1:0] look2_tag;
  data_t            look1_value;
  data_t            look2_value;
  logic             look1_done;
  logic             look2_done;

  // register file reads
  reg_ix_t rf_addr1;
  reg_ix_t rf_addr2;
  data_t   rf_data1;
  data_t   rf_data2;

  // buffer head to commit
  logic             head_valid;
  logic [TAG_W-1:0] head_tag;
  insn_class_t      head_class;
  reg_ix_t          head_dest;
  data_t            head_value;
  data_t            head_addr;
  logic             retire;

  issue_stage #(.ROB_DEPTH(ROB_DEPTH)) u_issue_stage (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .insn_valid  (insn_valid),
    .insn_class  (insn_class),
    .insn_dest   (insn_dest),
    .insn_src1   (insn_src1),
    .insn_src2   (insn_src2),
    .insn_ready  (insn_ready),
    .issue_tag   (issue_tag),
    .src1_ready  (src1_ready),
    .src1_value  (src1_value),
    .src1_tag    (src1_tag),
    .src2_ready  (src2_ready),
    .src2_value  (src2_value),
    .src2_tag    (src2_tag),
    .alloc_valid (alloc_valid),
    .alloc_class (alloc_class),
    .alloc_dest  (alloc_dest),
    .alloc_tag   (alloc_tag),
    .rob_full    (rob_full),
    .look1_tag   (look1_tag),
    .look2_tag   (look2_tag),
    .look1_value (look1_value),
    .look1_done  (look1_done),
    .look2_value (look2_value),
    .look2_done  (look2_done),
    .rf_addr1    (rf_addr1),
    .rf_addr2    (rf_addr2),
    .rf_data1    (rf_data1),
    .rf_data2    (rf_data2),
    .retire      (retire),
    .head_tag    (head_tag)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .alloc_valid (alloc_valid),
    .alloc_class (alloc_class),
    .alloc_dest  (alloc_dest),
    .alloc_tag   (alloc_tag),
    .rob_full    (rob_full),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value),
    .cdb_addr    (cdb_addr),
    .look1_tag   (look1_tag),
    .look2_tag   (look2_tag),
    .look1_value (look1_value),
    .look1_done  (look1_done),
    .look2_value (look2_value),
    .look2_done  (look2_done),
    .head_valid  (head_valid),
    .head_tag    (head_tag),
    .head_class  (head_class),
    .head_dest   (head_dest),
    .head_value  (head_value),
    .head_addr   (head_addr),
    .retire      (retire)
  );

  commit_unit #(.ROB_DEPTH(ROB_DEPTH)) u_commit_unit (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .head_valid   (head_valid),
    .head_class   (head_class),
    .head_dest    (head_dest),
    .head_value   (head_value),
    .head_addr    (head_addr),
    .retire       (retire),
    .rf_addr1     (rf_addr1),
    .rf_addr2     (rf_addr2),
    .rf_data1     (rf_data1),
    .rf_data2     (rf_data2),
    .commit_valid (commit_valid),
    .commit_dest  (commit_dest),
    .commit_value (commit_value),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_sel       (wb_sel),
    .wb_ack       (wb_ack)
  );

endmodule

`default_nettype wire

/* verilog/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

  // machine word width
  localparam int DATA_W = 32;

  // values, store addresses and register contents
  typedef logic [DATA_W-1:0] data_t;

  // architectural register index x0 to x31
  typedef logic [4:0] reg_ix_t;

  // what an entry does when it reaches the head
  typedef enum logic [1:0] {
    // writes its destination register
    CLASS_ALU   = 2'd0,
    // writes memory through the bus
    CLASS_STORE = 2'd1,
    // retires with no effect
    CLASS_NOP   = 2'd2
  } insn_class_t;

endpackage

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  wire              clk_in,
  input  wire              rst_in,
  input  wire              alloc_valid,
  input  wire insn_class_t alloc_class,
  input  wire reg_ix_t     alloc_dest,
  output logic [TAG_W-1:0] alloc_tag,
  output logic             rob_full,
  input  wire              cdb_valid,
  input  wire [TAG_W-1:0]  cdb_tag,
  input  wire data_t       cdb_value,
  input  wire data_t       cdb_addr,
  input  wire [TAG_W-1:0]  look1_tag,
  input  wire [TAG_W-1:0]  look2_tag,
  output data_t            look1_value,
  output logic             look1_done,
  output data_t            look2_value,
  output logic             look2_done,
  output logic             head_valid,
  output logic [TAG_W-1:0] head_tag,
  output insn_class_t      head_class,
  output reg_ix_t          head_dest,
  output data_t            head_value,
  output data_t            head_addr,
  input  wire              retire
);

  // entry payload
  insn_class_t cls_q   [ROB_DEPTH];
  reg_ix_t     dest_q  [ROB_DEPTH];
  data_t       value_q [ROB_DEPTH];
  data_t       addr_q  [ROB_DEPTH];

  // per-slot completion
  logic [ROB_DEPTH-1:0] done_q;

  // pointers with one wrap bit above the slot index
  logic [TAG_W:0] head_q;
  logic [TAG_W:0] tail_q;
  logic [TAG_W:0] count;
  logic           rob_empty;

  // slots between head and tail
  logic [ROB_DEPTH-1:0] occupied;

  assign count     = tail_q - head_q;
  assign rob_empty = (head_q == tail_q);
  assign rob_full  = (head_q[TAG_W] != tail_q[TAG_W]) &&
                     (head_q[TAG_W-1:0] == tail_q[TAG_W-1:0]);

  assign alloc_tag = tail_q[TAG_W-1:0];

  always_comb begin
    logic [TAG_W-1:0] offset;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      offset      = TAG_W'(i) - head_q[TAG_W-1:0];
      occupied[i] = {1'b0, offset} < count;
    end
  end

  // operand lookups for the issue stage
  assign look1_value = value_q[look1_tag];
  assign look1_done  = done_q[look1_tag];
  assign look2_value = value_q[look2_tag];
  assign look2_done  = done_q[look2_tag];

  // head readout valid only once the oldest entry has completed
  assign head_tag   = head_q[TAG_W-1:0];
  assign head_valid = !rob_empty && done_q[head_tag];
  assign head_class = cls_q[head_tag];
  assign head_dest  = dest_q[head_tag];
  assign head_value = value_q[head_tag];
  assign head_addr  = addr_q[head_tag];

  // control state
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end else begin
      if (alloc_valid) begin
        tail_q <= tail_q + 1'b1;
        // nothing to wait for on a nop
        done_q[alloc_tag] <= (alloc_class == CLASS_NOP);
      end
      if (cdb_valid) begin
        done_q[cdb_tag] <= 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  // payload written at allocation and completion
  always_ff @(posedge clk_in) begin
    if (alloc_valid) begin
      cls_q[alloc_tag]  <= alloc_class;
      dest_q[alloc_tag] <= alloc_dest;
    end
    if (cdb_valid) begin
      // for stores value is the data and addr the target
      value_q[cdb_tag] <= cdb_value;
      addr_q[cdb_tag]  <= cdb_addr;
    end
  end

  // intake must stop while every slot is in use
  a_no_alloc_when_full: assert property (
    @(posedge clk_in) disable iff (rst_in) alloc_valid |-> !rob_full
  ) else $error("allocation while reorder buffer full");

  // execution side may only complete live, pending entries
  a_cdb_target_live: assert property (
    @(posedge clk_in) disable iff (rst_in)
      cdb_valid |-> occupied[cdb_tag] && !done_q[cdb_tag]
  ) else $error("CDB strobe to free or already done slot %0d", cdb_tag);

  // commit unit must wait for a completed head
  a_retire_done_head: assert property (
    @(posedge clk_in) disable iff (rst_in) retire |-> head_valid
  ) else $error("retire without a completed head entry");

endmodule

`default_nettype wire
